//--- hdl/descriptors.mem
// One hex byte per entry, in ROM index order
// Device descriptor, bytes 0 to 17
12 01 00 02 00 00 00 40 34 12 78 56 00 01 00 00 00 01
// Configuration 18 to 26, interface 27 to 35, endpoint 36 to 42
09 02 19 00 01 01 00 80 32
09 04 00 00 01 FF 00 00 00
07 05 81 03 08 00 0A

//--- files.f
+incdir+sim
hdl/ep0Pkg.sv
hdl/setupCapture.sv
hdl/requestDecoder.sv
hdl/deviceStateCtrl.sv
hdl/descriptorRom.sv
hdl/ep0DataSender.sv
hdl/controlEndpoint0.sv
sim/ep0Tb.sv

//--- Bender.yml
package:
  name: control_endpoint0

sources:
  - files:
      - hdl/ep0Pkg.sv
      - hdl/setupCapture.sv
      - hdl/requestDecoder.sv
      - hdl/deviceStateCtrl.sv
      - hdl/descriptorRom.sv
      - hdl/ep0DataSender.sv
      - hdl/controlEndpoint0.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/ep0Tb.sv

//--- sim/ep0HostTasks.svh
`ifndef EP0_HOST_TASKS_SVH
`define EP0_HOST_TASKS_SVH

// Host side of the packet engine
// Every task starts and ends 5 ns after a rising edge

task automatic nextCycle();
    @(posedge clk48);
    #5;
endtask

// One-cycle start pulse while the token ID stays on the bus afterwards
task automatic sendToken(input logic [1:0] tokenId);
    tokenStart.gotStart = 1'b1;
    tokenStart.tokenId = tokenId;
    nextCycle();
    tokenStart.gotStart = 1'b0;
endtask

// SETUP token, DATA0 PID, eight setup bytes, then a good transDone
task automatic runSetup(input logic [63:0] rawPkt, output bit ok);
    logic [71:0] bytes;
    int waitCnt;
    ok = 1'b1;
    bytes = {rawPkt, 8'hC3};
    // Nothing is captured before the SETUP token
    checkValue("setupFull_o", setupFull, 1'b1);
    sendToken(TOKEN_SETUP);
    for (int i = 0; i < 9 && ok; i++) begin
        fillIn.dataValid = 1'b1;
        fillIn.data = bytes[8*i +: 8];
        waitCnt = 0;
        @(negedge clk48);
        while (setupFull && waitCnt < TIMEOUT_CYCLES) begin
            waitCnt++;
            @(negedge clk48);
        end
        if (setupFull) begin
            ok = 1'b0;
            reportTimeout("setupFull_o to drop");
        end
        // Byte is taken on this edge
        nextCycle();
    end
    // All eight setup bytes are held
    checkValue("setupFull_o", setupFull, 1'b1);
    fillIn.dataValid = 1'b0;
    fillIn.transDone = 1'b1;
    fillIn.transSuccess = 1'b1;
    nextCycle();
    fillIn.transDone = 1'b0;
    fillIn.transSuccess = 1'b0;
endtask

// Holds popData until a byte is available, then takes it
task automatic popByte(output logic [7:0] data, output logic last, output bit ok);
    int waitCnt;
    waitCnt = 0;
    ok = 1'b1;
    popReq.popData = 1'b1;
    @(negedge clk48);
    while (!popResp.dataAvailable && waitCnt < TIMEOUT_CYCLES) begin
        waitCnt++;
        @(negedge clk48);
    end
    data = popResp.data;
    last = popResp.isLastByte;
    if (!popResp.dataAvailable) begin
        ok = 1'b0;
        reportTimeout("dataAvailable to rise");
    end
    nextCycle();
    popReq.popData = 1'b0;
endtask

// Host ACK or lost packet at the end of an IN transaction
task automatic endInTransaction(input bit success);
    popReq.transDone = 1'b1;
    popReq.transSuccess = success;
    nextCycle();
    popReq.transDone = 1'b0;
    popReq.transSuccess = 1'b0;
endtask

`endif

//--- sim/ep0Tb.sv
`timescale 1ns/1ns

module ep0Tb;
    import ep0Pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    // Upper PID bits of an OUT token
    localparam logic [1:0] TOKEN_OUT = 2'b00;

    logic clk48;
    logic arstN;
    logic usbReset;
    tokenStart_t tokenStart;
    fillIn_t fillIn;
    popReq_t popReq;
    logic setupFull;
    popResp_t popResp;
    resp_t resp;
    logic [DEV_ADDR_WID-1:0] deviceAddr;
    logic [DEV_CONF_WID-1:0] deviceConf;
    logic ackUsbReset;

    // Reference model
    logic [7:0] romModel [ROM_BYTES];
    devState_t mState;
    logic [6:0] mAddr;
    logic [7:0] mConf;
    logic mToggle;
    logic mError;
    logic mDevToHost;
    logic mSendConf;
    int mIdx;
    int mLeft;
    int errorCount;
    int checkCount;

    controlEndpoint0 dut_i (
        .clk48_i(clk48),
        .arstN_i(arstN),
        .usbResetDetected_i(usbReset),
        .tokenStart_i(tokenStart),
        .fillIn_i(fillIn),
        .popReq_i(popReq),
        .setupFull_o(setupFull),
        .popResp_o(popResp),
        .resp_o(resp),
        .deviceAddr_o(deviceAddr),
        .deviceConf_o(deviceConf),
        .ackUsbReset_o(ackUsbReset)
    );

    `include "ep0HostTasks.svh"

    initial begin
        clk48 = 1'b0;
        forever #20 clk48 = ~clk48;
    end

    // ==============================
    // Checks and model
    // ==============================
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    endtask

    function automatic logic [63:0] makeSetup(input logic [7:0] bmReq, input logic [7:0] bReq,
                                              input logic [15:0] wValue,
                                              input logic [15:0] wLength);
        return {wLength, 16'h0000, wValue, bReq, bmReq};
    endfunction

    task automatic modelReset();
        mState = DEFAULT;
        mAddr = '0;
        mConf = '0;
        mToggle = 1'b0;
        mError = 1'b0;
        mDevToHost = 1'b0;
        mLeft = 0;
    endtask

    // Standard request rules on the setup bytes in wire order
    task automatic modelSetup(input logic [63:0] raw);
        logic dirIn;
        logic [7:0] bReq;
        logic [15:0] wValue;
        logic [15:0] wLength;
        int descLen;
        dirIn = raw[7];
        bReq = raw[15:8];
        wValue = raw[31:16];
        wLength = raw[63:48];
        mError = 1'b1;
        mDevToHost = 1'b0;
        mSendConf = 1'b0;
        mLeft = 0;
        descLen = 0;
        case (bReq)
            SET_ADDRESS: begin
                if (!dirIn && mState != CONFIGURED) begin
                    mError = 1'b0;
                    mAddr = wValue[6:0];
                    mState = (wValue[6:0] == 0) ? DEFAULT : ADDRESSED;
                end
            end
            SET_CONFIGURATION: begin
                if (!dirIn && mState != DEFAULT) begin
                    mError = 1'b0;
                    mConf = wValue[7:0];
                    mState = (wValue[7:0] == 0) ? ADDRESSED : CONFIGURED;
                end
            end
            GET_CONFIGURATION: begin
                if (dirIn && mState != DEFAULT) begin
                    mError = 1'b0;
                    mDevToHost = 1'b1;
                    mSendConf = 1'b1;
                    mLeft = 1;
                end
            end
            GET_DESCRIPTOR: begin
                if (wValue[15:8] == 8'd1) begin
                    mIdx = DEV_DESC_OFFSET;
                    descLen = DEV_DESC_LEN;
                end else if (wValue[15:8] == 8'd2 && wValue[7:0] == 8'd0) begin
                    mIdx = CONF_DESC_OFFSET;
                    descLen = CONF_DESC_LEN;
                end
                if (dirIn && descLen != 0) begin
                    mError = 1'b0;
                    mDevToHost = 1'b1;
                    mLeft = (wLength < descLen) ? wLength : descLen;
                end
            end
            default: begin
            end
        endcase
    endtask

    // Outputs hold for one cycle after transDone and move on the second
    task automatic doRequest(input logic [63:0] raw);
        bit ok;
        runSetup(raw, ok);
        checkValue("deviceAddr_o", deviceAddr, mAddr);
        checkValue("deviceConf_o", deviceConf, mConf);
        modelSetup(raw);
        nextCycle();
        checkValue("deviceAddr_o", deviceAddr, mAddr);
        checkValue("deviceConf_o", deviceConf, mConf);
        checkValue("ackUsbReset_o", ackUsbReset, mState == DEFAULT);
    endtask

    task automatic checkHandshake();
        sendToken(TOKEN_OUT);
        @(negedge clk48);
        checkValue("resp_o.handshakePid", resp.handshakePid, !mDevToHost || mError);
        checkValue("resp_o.packetId", resp.packetId, mError ? RESP_STALL : RESP_ACK);
        nextCycle();
    endtask

    // IN transactions of random size until both the model and the DUT run dry
    task automatic runDataStage(input bit mayFail, output int sent);
        int burst;
        int rounds;
        bit success;
        bit ok;
        logic [7:0] data;
        logic last;
        sent = 0;
        rounds = 0;
        ok = 1'b1;
        while ((mLeft > 0 || popResp.dataAvailable) && ok && rounds < TIMEOUT_CYCLES) begin
            rounds++;
            sendToken(TOKEN_IN);
            @(negedge clk48);
            checkValue("resp_o.packetId", resp.packetId, {mToggle, 1'b0});
            nextCycle();
            burst = $urandom_range(8, 1);
            if (mLeft > 0 && burst > mLeft) begin
                burst = mLeft;
            end
            for (int i = 0; i < burst && ok; i++) begin
                popByte(data, last, ok);
                if (ok) begin
                    checkValue("popResp_o.data", data,
                               mSendConf ? mConf : romModel[mIdx + i]);
                    checkValue("popResp_o.isLastByte", last, mLeft - i == 1);
                end
            end
            success = mayFail ? ($urandom_range(3, 0) != 0) : 1'b1;
            endInTransaction(success);
            // A lost transaction replays from the committed point
            if (success && ok) begin
                mIdx += burst;
                mLeft -= burst;
                sent += burst;
                mToggle = !mToggle;
            end
        end
        checkValue("popResp_o.dataAvailable", popResp.dataAvailable, 1'b0);
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int wLen;
        int sent;
        logic [7:0] value;
        logic [7:0] code;
        logic [7:0] data;
        logic last;
        bit ok;
        void'($urandom(94008));
        errorCount = 0;
        checkCount = 0;
        arstN = 1'b0;
        usbReset = 1'b0;
        tokenStart = '0;
        fillIn = '0;
        popReq = '0;
        $readmemh("hdl/descriptors.mem", romModel);
        modelReset();
        repeat (2) @(posedge clk48);
        #5;
        arstN = 1'b1;
        nextCycle();

        // Device descriptor clamped to wLength
        wLen = $urandom_range(64, 1);
        doRequest(makeSetup(8'h80, GET_DESCRIPTOR, 16'h0100, wLen));
        runDataStage(1'b0, sent);
        checkValue("bytes sent", sent, (wLen < 18) ? wLen : 18);
        checkHandshake();

        // Configuration bundle with lost IN transactions
        doRequest(makeSetup(8'h80, GET_DESCRIPTOR, 16'h0200, 16'd255));
        runDataStage(1'b1, sent);
        checkValue("bytes sent", sent, 25);

        // Address set, cleared, set again
        value = $urandom_range(127, 1);
        doRequest(makeSetup(8'h00, SET_ADDRESS, {8'h00, value}, 16'd0));
        checkHandshake();
        doRequest(makeSetup(8'h00, SET_ADDRESS, 16'h0000, 16'd0));
        value = $urandom_range(127, 1);
        doRequest(makeSetup(8'h00, SET_ADDRESS, {8'h00, value}, 16'd0));

        // Configure, then read the value back
        value = $urandom_range(255, 1);
        doRequest(makeSetup(8'h00, SET_CONFIGURATION, {8'h00, value}, 16'd0));
        checkHandshake();
        doRequest(makeSetup(8'h80, GET_CONFIGURATION, 16'h0000, $urandom_range(64, 1)));
        runDataStage(1'b0, sent);
        checkValue("bytes sent", sent, 1);

        // Unsupported request and bad descriptor index stall
        do begin
            code = $urandom_range(255, 0);
        end while (code == SET_ADDRESS || code == GET_DESCRIPTOR ||
                   code == GET_CONFIGURATION || code == SET_CONFIGURATION);
        doRequest(makeSetup($urandom_range(255, 0), code, $urandom_range(65535, 0), 16'd8));
        checkHandshake();
        doRequest(makeSetup(8'h80, GET_DESCRIPTOR, 16'h0201, 16'd64));
        checkHandshake();

        // Bus reset in the middle of a data stage
        doRequest(makeSetup(8'h80, GET_DESCRIPTOR, 16'h0200, 16'd64));
        sendToken(TOKEN_IN);
        for (int i = 0; i < 2; i++) begin
            popByte(data, last, ok);
            checkValue("popResp_o.data", data, romModel[CONF_DESC_OFFSET + i]);
        end
        usbReset = 1'b1;
        repeat (2) nextCycle();
        usbReset = 1'b0;
        modelReset();
        checkValue("deviceAddr_o", deviceAddr, 0);
        checkValue("deviceConf_o", deviceConf, 0);
        checkValue("ackUsbReset_o", ackUsbReset, 1);
        checkValue("popResp_o.dataAvailable", popResp.dataAvailable, 0);
        // IN token is still on the bus, so the PID shows the cleared toggle
        checkValue("resp_o.packetId", resp.packetId, {mToggle, 1'b0});

        // Configuring from the default state stalls
        doRequest(makeSetup(8'h00, SET_CONFIGURATION, 16'h0001, 16'd0));
        checkHandshake();

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/controlEndpoint0.sv
`timescale 1ns/1ns

module controlEndpoint0 (
    input logic clk48_i,
    input logic arstN_i,
    input logic usbResetDetected_i,
    input ep0Pkg::tokenStart_t tokenStart_i,
    input ep0Pkg::fillIn_t fillIn_i,
    input ep0Pkg::popReq_t popReq_i,
    output logic setupFull_o,
    output ep0Pkg::popResp_t popResp_o,
    output ep0Pkg::resp_t resp_o,
    output logic [ep0Pkg::DEV_ADDR_WID-1:0] deviceAddr_o,
    output logic [ep0Pkg::DEV_CONF_WID-1:0] deviceConf_o,
    output logic ackUsbReset_o
);
    import ep0Pkg::*;

    setupPacket_t setupPkt;
    reqCmd_t reqCmd;
    devState_t devState;

    // Setup stage bytes into the packet register
    setupCapture setupCapture_i (
        .clk48_i(clk48_i),
        .arstN_i(arstN_i),
        .tokenStart_i(tokenStart_i),
        .fillIn_i(fillIn_i),
        .setupFull_o(setupFull_o),
        .setupPkt_o(setupPkt)
    );

    requestDecoder requestDecoder_i (
        .clk48_i(clk48_i),
        .arstN_i(arstN_i),
        .setupPkt_i(setupPkt),
        .fillIn_i(fillIn_i),
        .devState_i(devState),
        .reqCmd_o(reqCmd)
    );

    deviceStateCtrl deviceStateCtrl_i (
        .clk48_i(clk48_i),
        .arstN_i(arstN_i),
        .usbResetDetected_i(usbResetDetected_i),
        .reqCmd_i(reqCmd),
        .setupPkt_i(setupPkt),
        .devState_o(devState),
        .deviceAddr_o(deviceAddr_o),
        .deviceConf_o(deviceConf_o),
        .ackUsbReset_o(ackUsbReset_o)
    );

    // Data stage and response PID
    ep0DataSender ep0DataSender_i (
        .clk48_i(clk48_i),
        .arstN_i(arstN_i),
        .usbResetDetected_i(usbResetDetected_i),
        .tokenStart_i(tokenStart_i),
        .reqCmd_i(reqCmd),
        .popReq_i(popReq_i),
        .deviceConf_i(deviceConf_o),
        .popResp_o(popResp_o),
        .resp_o(resp_o)
    );

endmodule

//--- hdl/ep0DataSender.sv
`timescale 1ns/1ns

module ep0DataSender (
    input logic clk48_i,
    input logic arstN_i,
    input logic usbResetDetected_i,
    input ep0Pkg::tokenStart_t tokenStart_i,
    input ep0Pkg::reqCmd_t reqCmd_i,
    input ep0Pkg::popReq_t popReq_i,
    input logic [ep0Pkg::DEV_CONF_WID-1:0] deviceConf_i,
    output ep0Pkg::popResp_t popResp_o,
    output ep0Pkg::resp_t resp_o
);
    import ep0Pkg::*;

    // Committed values restore a failed IN transaction
    logic [ROM_IDX_WID-1:0] commitIdx, transIdx;
    logic [15:0] commitLeft, transLeft;
    logic active;
    logic sendingConf;
    logic devToHost;
    logic error;
    logic toggle;
    logic [7:0] romData;
    logic popHandshake;

    descriptorRom rom_i (
        .readIdx_i(transIdx),
        .data_o(romData)
    );

    assign popResp_o.dataAvailable = active && transLeft != 16'd0;
    assign popResp_o.isLastByte = transLeft == 16'd1;
    assign popResp_o.data = sendingConf ? deviceConf_i : romData;
    assign popHandshake = popReq_i.popData && popResp_o.dataAvailable;

    // ==============================
    // Response PID
    // ==============================
    assign resp_o.handshakePid = !devToHost || error;
    assign resp_o.packetId = (tokenStart_i.tokenId == TOKEN_IN) ? {toggle, 1'b0} :
                             (error ? RESP_STALL : RESP_ACK);

    always_ff @(posedge clk48_i or negedge arstN_i) begin
        if (!arstN_i) begin
            {active, sendingConf, devToHost, error, toggle} <= '0;
            {commitIdx, transIdx, commitLeft, transLeft} <= '0;
        end else if (usbResetDetected_i) begin
            {active, devToHost, error, toggle} <= '0;
        end else if (tokenStart_i.gotStart && tokenStart_i.tokenId == TOKEN_SETUP) begin
            // New SETUP aborts the data stage
            active <= 1'b0;
            error <= 1'b0;
        end else if (reqCmd_i.valid) begin
            error <= reqCmd_i.error;
            devToHost <= reqCmd_i.sendDesc || reqCmd_i.sendConf;
            active <= reqCmd_i.sendDesc || reqCmd_i.sendConf;
            sendingConf <= reqCmd_i.sendConf;
            commitIdx <= reqCmd_i.romStart;
            transIdx <= reqCmd_i.romStart;
            commitLeft <= reqCmd_i.byteCount;
            transLeft <= reqCmd_i.byteCount;
        end else if (popHandshake) begin
            transIdx <= transIdx + 1'b1;
            transLeft <= transLeft - 16'd1;
        end else if (popReq_i.transDone) begin
            if (popReq_i.transSuccess) begin
                commitIdx <= transIdx;
                commitLeft <= transLeft;
                toggle <= !toggle;
            end else begin
                // Host missed it, replay the same bytes
                transIdx <= commitIdx;
                transLeft <= commitLeft;
            end
        end
    end

endmodule

//--- hdl/descriptorRom.sv
`timescale 1ns/1ns

module descriptorRom (
    input logic [ep0Pkg::ROM_IDX_WID-1:0] readIdx_i,
    output logic [7:0] data_o
);
    import ep0Pkg::*;

    logic [7:0] rom [ROM_BYTES];

    // Device descriptor first, then the configuration bundle
    initial begin
        $readmemh(ROM_FILE, rom);
    end

    // Combinational read, zero past the end
    always_comb begin
        if (readIdx_i < ROM_BYTES) begin
            data_o = rom[readIdx_i];
        end else begin
            data_o = 8'h00;
        end
    end

endmodule

//--- hdl/deviceStateCtrl.sv
`timescale 1ns/1ns

module deviceStateCtrl (
    input logic clk48_i,
    input logic arstN_i,
    input logic usbResetDetected_i,
    input ep0Pkg::reqCmd_t reqCmd_i,
    input ep0Pkg::setupPacket_t setupPkt_i,
    output ep0Pkg::devState_t devState_o,
    output logic [ep0Pkg::DEV_ADDR_WID-1:0] deviceAddr_o,
    output logic [ep0Pkg::DEV_CONF_WID-1:0] deviceConf_o,
    output logic ackUsbReset_o
);
    import ep0Pkg::*;

    logic [7:0] newValue;

    assign newValue = setupPkt_i.wValue.value.newValue;

    // Reset is acknowledged as long as we sit in default
    assign ackUsbReset_o = devState_o == DEFAULT;

    always_ff @(posedge clk48_i or negedge arstN_i) begin
        if (!arstN_i) begin
            devState_o <= DEFAULT;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (usbResetDetected_i) begin
            // Bus reset wins over any pending command
            devState_o <= DEFAULT;
            deviceAddr_o <= '0;
            deviceConf_o <= '0;
        end else if (reqCmd_i.valid && reqCmd_i.setConf) begin
            deviceConf_o <= newValue[DEV_CONF_WID-1:0];
            // Config value 0 drops back to addressed
            devState_o <= (newValue == 8'd0) ? ADDRESSED : CONFIGURED;
        end else if (reqCmd_i.valid && reqCmd_i.setAddr) begin
            deviceAddr_o <= newValue[DEV_ADDR_WID-1:0];
            // Address 0 means default again
            if (newValue[DEV_ADDR_WID-1:0] == '0) begin
                devState_o <= DEFAULT;
            end else begin
                devState_o <= ADDRESSED;
            end
        end
    end

endmodule

//--- hdl/requestDecoder.sv
`timescale 1ns/1ns

module requestDecoder (
    input logic clk48_i,
    input logic arstN_i,
    input ep0Pkg::setupPacket_t setupPkt_i,
    input ep0Pkg::fillIn_t fillIn_i,
    input ep0Pkg::devState_t devState_i,
    output ep0Pkg::reqCmd_t reqCmd_o
);
    import ep0Pkg::*;

    reqCmd_t nextCmd;
    logic isDevToHost;
    logic descOk;
    logic [15:0] descLen;
    logic setupDone;

    assign isDevToHost = setupPkt_i.bmRequestType.devToHost;
    assign setupDone = fillIn_i.transDone && fillIn_i.transSuccess;

    // ==============================
    // Request checks
    // ==============================
    always_comb begin
        nextCmd = '0;
        nextCmd.valid = 1'b1;
        descOk = 1'b0;
        descLen = 16'd0;

        case (setupPkt_i.bRequest)
            SET_ADDRESS: begin
                // Not allowed once configured
                if (!isDevToHost && devState_i != CONFIGURED) begin
                    nextCmd.setAddr = 1'b1;
                end else begin
                    nextCmd.error = 1'b1;
                end
            end
            SET_CONFIGURATION: begin
                // Needs an address first
                if (!isDevToHost && devState_i != DEFAULT) begin
                    nextCmd.setConf = 1'b1;
                end else begin
                    nextCmd.error = 1'b1;
                end
            end
            GET_CONFIGURATION: begin
                if (isDevToHost && devState_i != DEFAULT) begin
                    nextCmd.sendConf = 1'b1;
                    // Always a single byte
                    nextCmd.byteCount = 16'd1;
                end else begin
                    nextCmd.error = 1'b1;
                end
            end
            GET_DESCRIPTOR: begin
                if (setupPkt_i.wValue.desc.descType == DEVICE) begin
                    descOk = 1'b1;
                    nextCmd.romStart = DEV_DESC_OFFSET;
                    descLen = DEV_DESC_LEN;
                end else if (setupPkt_i.wValue.desc.descType == CONFIGURATION &&
                             setupPkt_i.wValue.desc.descIndex == 8'd0) begin
                    // Single configuration, index 0 only
                    descOk = 1'b1;
                    nextCmd.romStart = CONF_DESC_OFFSET;
                    descLen = CONF_DESC_LEN;
                end

                if (isDevToHost && descOk) begin
                    nextCmd.sendDesc = 1'b1;
                    // Clamp to what the host asked for
                    if (setupPkt_i.wLength < descLen) begin
                        nextCmd.byteCount = setupPkt_i.wLength;
                    end else begin
                        nextCmd.byteCount = descLen;
                    end
                end else begin
                    nextCmd.romStart = '0;
                    nextCmd.error = 1'b1;
                end
            end
            default: begin
                // Anything else stalls
                nextCmd.error = 1'b1;
            end
        endcase
    end

    // Command lives for exactly one cycle
    always_ff @(posedge clk48_i or negedge arstN_i) begin
        if (!arstN_i) begin
            reqCmd_o <= '0;
        end else if (setupDone) begin
            reqCmd_o <= nextCmd;
        end else begin
            reqCmd_o <= '0;
        end
    end

endmodule

//--- hdl/setupCapture.sv
`timescale 1ns/1ns

module setupCapture (
    input logic clk48_i,
    input logic arstN_i,
    input ep0Pkg::tokenStart_t tokenStart_i,
    input ep0Pkg::fillIn_t fillIn_i,
    output logic setupFull_o,
    output ep0Pkg::setupPacket_t setupPkt_o
);
    import ep0Pkg::*;

    logic capturing;
    logic pidSkipped;
    logic [3:0] byteCnt;
    logic takeByte;

    // Full outside a SETUP transaction or once all eight bytes are in
    assign setupFull_o = !capturing || (pidSkipped && byteCnt == SETUP_BYTES);
    assign takeByte = fillIn_i.dataValid && !setupFull_o;

    always_ff @(posedge clk48_i or negedge arstN_i) begin
        if (!arstN_i) begin
            capturing <= 1'b0;
            pidSkipped <= 1'b0;
            byteCnt <= 4'd0;
        end else if (tokenStart_i.gotStart) begin
            // Only a SETUP token opens the capture window
            capturing <= tokenStart_i.tokenId == TOKEN_SETUP;
            pidSkipped <= 1'b0;
            byteCnt <= 4'd0;
        end else if (capturing) begin
            if (fillIn_i.transDone) begin
                capturing <= 1'b0;
            end else if (takeByte) begin
                // First byte is the DATA0 PID
                if (!pidSkipped) begin
                    pidSkipped <= 1'b1;
                end else begin
                    byteCnt <= byteCnt + 4'd1;
                end
            end
        end
    end

    // Shift in at the top, first byte drifts down to bit 0
    always_ff @(posedge clk48_i) begin
        if (takeByte && pidSkipped) begin
            setupPkt_o <= setupPacket_t'({fillIn_i.data, setupPkt_o[63:8]});
        end
    end

endmodule

//--- hdl/ep0Pkg.sv
package ep0Pkg;

    // ==============================
    // Sizes and ROM layout
    // ==============================
    localparam int DEV_ADDR_WID = 7;
    localparam int DEV_CONF_WID = 8;
    localparam int SETUP_BYTES = 8;
    localparam int ROM_BYTES = 43;
    localparam int ROM_IDX_WID = 6;
    localparam string ROM_FILE = "hdl/descriptors.mem";

    // Device descriptor sits at the start of the ROM
    localparam logic [ROM_IDX_WID-1:0] DEV_DESC_OFFSET = 6'd0;
    localparam logic [15:0] DEV_DESC_LEN = 16'd18;
    // Configuration, interface and endpoint descriptor back to back
    localparam logic [ROM_IDX_WID-1:0] CONF_DESC_OFFSET = 6'd18;
    localparam logic [15:0] CONF_DESC_LEN = 16'd25;

    // ==============================
    // PID codes, upper two PID bits
    // ==============================
    localparam logic [1:0] TOKEN_SETUP = 2'b11;
    localparam logic [1:0] TOKEN_IN = 2'b10;
    localparam logic [1:0] RESP_ACK = 2'b00;
    localparam logic [1:0] RESP_STALL = 2'b11;

    // Standard requests handled by endpoint 0
    typedef enum logic [7:0] {
        SET_ADDRESS = 8'd5,
        GET_DESCRIPTOR = 8'd6,
        GET_CONFIGURATION = 8'd8,
        SET_CONFIGURATION = 8'd9
    } reqCode_t;

    typedef enum logic [7:0] {
        DEVICE = 8'd1,
        CONFIGURATION = 8'd2
    } descType_t;

    // wValue is read either as a descriptor selector or as a new address/config
    typedef union packed {
        struct packed {
            descType_t descType;
            logic [7:0] descIndex;
        } desc;
        struct packed {
            logic [7:0] unused;
            logic [7:0] newValue;
        } value;
    } setupValue_u;

    typedef struct packed {
        logic devToHost;
        logic [1:0] reqType;
        logic [4:0] recipient;
    } requestType_t;

    // Little-endian wire order, so byte 0 ends up in the LSBs
    typedef struct packed {
        logic [15:0] wLength;
        logic [15:0] wIndex;
        setupValue_u wValue;
        reqCode_t bRequest;
        requestType_t bmRequestType;
    } setupPacket_t;

    // ==============================
    // Packet engine side
    // ==============================
    typedef struct packed {
        logic gotStart;
        logic [1:0] tokenId;
    } tokenStart_t;

    typedef struct packed {
        logic dataValid;
        logic [7:0] data;
        logic transDone;
        logic transSuccess;
    } fillIn_t;

    typedef struct packed {
        logic popData;
        logic transDone;
        logic transSuccess;
    } popReq_t;

    typedef struct packed {
        logic dataAvailable;
        logic isLastByte;
        logic [7:0] data;
    } popResp_t;

    typedef struct packed {
        logic handshakePid;
        logic [1:0] packetId;
    } resp_t;

    typedef enum logic [1:0] {
        DEFAULT,
        ADDRESSED,
        CONFIGURED
    } devState_t;

    // One-cycle command out of the request decoder
    typedef struct packed {
        logic valid;
        logic setAddr;
        logic setConf;
        logic sendDesc;
        logic sendConf;
        logic error;
        logic [ROM_IDX_WID-1:0] romStart;
        logic [15:0] byteCount;
    } reqCmd_t;

endpackage
